/* src.f */
+incdir+include
rtl/color_pkg.sv
rtl/tile_pkg.sv
rtl/task_if.sv
rtl/task_queue.sv
rtl/graph_mem.sv
rtl/color_rw.sv
rtl/color_worker.sv
rtl/color_tile.sv
verif/color_tile_sva.sv
verif/color_tile_tb.sv

/* Makefile */
# Verilator build and run for the graph-coloring tile

VERILATOR ?= verilator
TOP ?= color_tile_tb
DUT_TOP ?= color_tile
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?=
LINT_FLAGS ?= -Wall

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG) || \
		(echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/color_tile_tb.sv */
`timescale 1ns/1ns
`include "color_params.svh"

module color_tile_tb;

   logic clk;
   logic rstn;
   logic wb_cyc;
   logic wb_stb;
   logic wb_we;
   logic [15:0] wb_adr;
   logic [31:0] wb_dat_w;
   logic [31:0] wb_dat_r;
   logic wb_ack;
   logic busy;

   // undirected graph as an adjacency matrix
   bit adj [16][16];
   int n_v;
   int exp_color [16];
   int got_color [16];
   string cur_test;
   int test_err0;
   int errors;
   int checks;
   int tests_run;
   int tests_failed;
   int cmp_req;
   int cmp_ack;

   color_tile dut (
      .clk(clk),
      .rstn(rstn),
      .wb_cyc(wb_cyc),
      .wb_stb(wb_stb),
      .wb_we(wb_we),
      .wb_adr(wb_adr),
      .wb_dat_w(wb_dat_w),
      .wb_dat_r(wb_dat_r),
      .wb_ack(wb_ack),
      .busy(busy)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic abort_run(input string why);
      $display("timeout: %s", why);
      $display("=== FAIL ===");
      $finish;
   endtask

   task automatic check_value(input string name, input int exp_v, input int act_v);
      checks++;
      assert (act_v == exp_v) else begin
         $display("[ERROR] %s, %s: expected %0d actual %0d", cur_test, name, exp_v, act_v);
         errors++;
      end
   endtask

   task automatic start_test(input string name);
      cur_test = name;
      test_err0 = errors;
   endtask

   task automatic end_test();
      tests_run++;
      if (errors == test_err0) begin
         $display("test %s: ok", cur_test);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d errors", cur_test, errors - test_err0);
      end
   endtask

   // bus cycle ends on the edge after ack is seen
   task automatic wb_write(input logic [15:0] adr, input logic [31:0] dat);
      int n;
      @(posedge clk);
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      wb_we <= 1'b1;
      wb_adr <= adr;
      wb_dat_w <= dat;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!wb_ack && n < 20);
      if (!wb_ack) begin
         abort_run($sformatf("no ack for write to 0x%h", adr));
      end
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we <= 1'b0;
   endtask

   task automatic wb_read(input logic [15:0] adr, output logic [31:0] dat);
      int n;
      @(posedge clk);
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      wb_we <= 1'b0;
      wb_adr <= adr;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!wb_ack && n < 20);
      if (!wb_ack) begin
         abort_run($sformatf("no ack for read from 0x%h", adr));
      end
      dat = wb_dat_r;
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
   endtask

   function automatic logic [15:0] vtx_addr(input int v, input int w);
      return 16'(`COLOR_VTX_BASE + v * 16 + w * 4);
   endfunction

   task automatic clear_graph(input int n);
      n_v = n;
      for (int a = 0; a < 16; a++) begin
         for (int b = 0; b < 16; b++) begin
            adj[a][b] = 1'b0;
         end
      end
   endtask

   task automatic add_edge(input int a, input int b);
      adj[a][b] = 1'b1;
      adj[b][a] = 1'b1;
   endtask

   task automatic make_random(input int n, input int m);
      int a;
      int b;
      int k;
      int tries;
      clear_graph(n);
      k = 0;
      tries = 0;
      while (k < m && tries < 400) begin
         a = $urandom_range(n - 1);
         b = $urandom_range(n - 1);
         tries++;
         if (a != b && !adj[a][b]) begin
            add_edge(a, b);
            k++;
         end
      end
   endtask

   // greedy coloring, highest degree first, lower id on a tie
   function automatic void ref_coloring();
      int deg [16];
      bit done [16];
      bit used [17];
      int best;
      for (int v = 0; v < n_v; v++) begin
         deg[v] = 0;
         done[v] = 1'b0;
         for (int u = 0; u < n_v; u++) begin
            deg[v] += int'(adj[v][u]);
         end
      end
      repeat (n_v) begin
         best = -1;
         for (int v = 0; v < n_v; v++) begin
            if (!done[v] && (best < 0 || deg[v] > deg[best])) begin
               best = v;
            end
         end
         for (int c = 0; c < 17; c++) begin
            used[c] = 1'b0;
         end
         for (int u = 0; u < n_v; u++) begin
            if (adj[best][u] && done[u]) begin
               used[exp_color[u]] = 1'b1;
            end
         end
         exp_color[best] = 0;
         while (used[exp_color[best]]) begin
            exp_color[best]++;
         end
         done[best] = 1'b1;
      end
   endfunction

   // records start with all degrees pending and no colors seen
   task automatic load_graph();
      int deg;
      int eo;
      eo = 0;
      for (int v = 0; v < n_v; v++) begin
         deg = 0;
         for (int u = 0; u < n_v; u++) begin
            if (adj[v][u]) begin
               wb_write(16'(`COLOR_EDGE_BASE + (eo + deg) * 4), 32'(u));
               deg++;
            end
         end
         wb_write(vtx_addr(v, 0), 32'(eo));
         wb_write(vtx_addr(v, 1), {16'(deg), 16'd0});
         wb_write(vtx_addr(v, 2), 32'd0);
         wb_write(vtx_addr(v, 3), {16'(deg), 16'hFFFF});
         eo += deg;
      end
      wb_write(`COLOR_REG_NUM_V, 32'(n_v));
   endtask

   task automatic color_graph(input int limit);
      int n;
      logic [31:0] rd;
      load_graph();
      wb_write(`COLOR_REG_ENQ_LIMIT, 32'(limit));
      wb_write(`COLOR_REG_START, 32'd1);
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!busy && n < 50);
      if (!busy) begin
         abort_run("busy never rose after start");
      end
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (busy && n < 20000);
      if (busy) begin
         abort_run($sformatf("busy still high in %s", cur_test));
      end
      for (int v = 0; v < n_v; v++) begin
         wb_read(vtx_addr(v, 3), rd);
         got_color[v] = int'(rd[15:0]);
      end
      ref_coloring();
      cmp_req++;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (cmp_ack != cmp_req && n < 4);
      if (cmp_ack != cmp_req) begin
         abort_run("color comparison never ran");
      end
   endtask

   always @(negedge clk) begin
      if (cmp_req != cmp_ack) begin
         for (int v = 0; v < n_v; v++) begin
            check_value($sformatf("vertex %0d", v), exp_color[v], got_color[v]);
         end
         cmp_ack = cmp_ack + 1;
      end
   end

   initial begin
      logic [31:0] rd;
      int n;
      int m;
      int limits [3];
      rstn = 1'b0;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      wb_adr = '0;
      wb_dat_w = '0;
      errors = 0;
      checks = 0;
      tests_run = 0;
      tests_failed = 0;
      cmp_req = 0;
      cmp_ack = 0;
      n_v = 0;
      limits = '{1, 3, 8};
      void'($urandom(32'he084));
      repeat (3) @(posedge clk);
      rstn <= 1'b1;

      start_test("register readback");
      wb_read(`COLOR_REG_STATUS, rd);
      check_value("status after reset", 0, int'(rd));
      wb_write(`COLOR_REG_NUM_V, 32'd11);
      wb_read(`COLOR_REG_NUM_V, rd);
      check_value("num_v readback", 11, int'(rd));
      wb_write(`COLOR_REG_ENQ_LIMIT, 32'd5);
      wb_read(`COLOR_REG_ENQ_LIMIT, rd);
      check_value("enq_limit readback", 5, int'(rd));
      end_test();

      start_test("isolated vertices");
      clear_graph(6);
      color_graph(2);
      for (int v = 0; v < n_v; v++) begin
         check_value($sformatf("isolated vertex %0d", v), 0, got_color[v]);
      end
      end_test();

      // path 0-1-2-3 and triangle 4-5-6
      start_test("path and triangle");
      clear_graph(7);
      add_edge(0, 1);
      add_edge(1, 2);
      add_edge(2, 3);
      add_edge(4, 5);
      add_edge(5, 6);
      add_edge(4, 6);
      color_graph(3);
      check_value("tie goes to vertex 1", 0, got_color[1]);
      check_value("tie loser vertex 2", 1, got_color[2]);
      end_test();

      foreach (limits[i]) begin
         for (int g = 0; g < 2; g++) begin
            n = $urandom_range(16, 2);
            m = $urandom_range((n * (n - 1) / 2 < 24) ? n * (n - 1) / 2 : 24);
            start_test($sformatf("random n=%0d m=%0d limit=%0d", n, m, limits[i]));
            make_random(n, m);
            color_graph(limits[i]);
            end_test();
         end
      end

      start_test("single enq chunk");
      make_random(16, 24);
      color_graph(40);
      end_test();

      // leftover records from the first run must not matter
      start_test("restart with reloaded graph");
      make_random(12, 20);
      color_graph(3);
      make_random(9, 14);
      color_graph(3);
      end_test();

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

/* verif/color_tile_sva.sv */
`timescale 1ns/1ns
`include "color_params.svh"

module color_tile_sva import color_pkg::*, tile_pkg::*; (
   input logic clk,
   input logic rstn,
   input logic wb_stb,
   input logic wb_ack,
   input logic busy,
   input logic [$clog2(`COLOR_QUEUE_DEPTH):0] q_count,
   input logic push_valid,
   input logic push_ready,
   input color_task_t push_t,
   input job_kind_e push_kind,
   input logic job_valid,
   input logic job_ready,
   input color_task_t job_t,
   input job_kind_e job_kind
);

   localparam int QW = $clog2(`COLOR_QUEUE_DEPTH) + 1;

   // a full queue takes no task
   no_push_when_full: assert property (@(posedge clk) disable iff (!rstn)
      q_count <= QW'(`COLOR_QUEUE_DEPTH))
      else $error("task pushed into a full queue");

   push_payload_held: assert property (@(posedge clk) disable iff (!rstn)
      (push_valid && !push_ready) |=> (push_valid && $stable(push_t) && $stable(push_kind)))
      else $error("queue push payload changed before it was taken");

   job_payload_held: assert property (@(posedge clk) disable iff (!rstn)
      (job_valid && !job_ready) |=> (job_valid && $stable(job_t) && $stable(job_kind)))
      else $error("worker job payload changed before it was taken");

   ack_needs_stb: assert property (@(posedge clk) disable iff (!rstn)
      wb_ack |-> wb_stb)
      else $error("wb_ack high without wb_stb");

   // the run is over only once the queue has drained
   busy_falls_empty: assert property (@(posedge clk) disable iff (!rstn)
      $fell(busy) |-> (q_count == '0))
      else $error("busy fell with tasks left in the queue");

endmodule

bind color_tile color_tile_sva sva (
   .clk(clk),
   .rstn(rstn),
   .wb_stb(wb_stb),
   .wb_ack(wb_ack),
   .busy(busy),
   .q_count(u_queue.count),
   .push_valid(q_push.valid),
   .push_ready(q_push.ready),
   .push_t(q_push.t),
   .push_kind(q_push.kind),
   .job_valid(job.valid),
   .job_ready(job.ready),
   .job_t(job.t),
   .job_kind(job.kind)
);

/* rtl/color_tile.sv */
`timescale 1ns/1ns
`include "color_params.svh"

module color_tile import color_pkg::*, tile_pkg::*; (
   input logic clk,
   input logic rstn,
   input logic wb_cyc,
   input logic wb_stb,
   input logic wb_we,
   input logic [15:0] wb_adr,
   input logic [31:0] wb_dat_w,
   output logic [31:0] wb_dat_r,
   output logic wb_ack,
   output logic busy
);

   localparam int VW = $clog2(`COLOR_MAX_VERTICES);
   localparam int EW = $clog2(`COLOR_MAX_EDGES);

   task_if q_pop ();
   task_if job ();
   task_if wk_out ();
   task_if q_push ();

   logic [15:0] num_v;
   logic [15:0] enq_limit;
   logic start_pend;
   logic inj_valid;
   logic inj_fire;
   logic rw_idle;
   logic wk_idle;
   logic wr_cyc;
   logic rd_req;
   logic hit_vtx;
   logic hit_edge;
   logic [31:0] reg_rd;
   logic [31:0] vtx_a_rdata;
   logic [31:0] edge_a_rdata;

   logic vtx_b_en;
   logic vtx_b_we;
   logic [VW-1:0] vtx_b_addr;
   vertex_rec_t vtx_b_wdata;
   vertex_rec_t vtx_b_rdata;
   logic edge_b_en;
   logic [EW-1:0] edge_b_addr;
   logic [31:0] edge_b_rdata;

   assign hit_vtx = (wb_adr & 16'hF000) == `COLOR_VTX_BASE;
   assign hit_edge = (wb_adr & 16'hF000) == `COLOR_EDGE_BASE;
   // writes land on the ack cycle, reads are issued one cycle earlier
   assign wr_cyc = wb_ack && wb_we;
   assign rd_req = wb_cyc && wb_stb && !wb_ack && !wb_we;

   always_comb begin
      case (wb_adr)
         `COLOR_REG_NUM_V: reg_rd = {16'd0, num_v};
         `COLOR_REG_ENQ_LIMIT: reg_rd = {16'd0, enq_limit};
         `COLOR_REG_STATUS: reg_rd = {31'd0, busy};
         default: reg_rd = '0;
      endcase
      if (hit_vtx) begin
         wb_dat_r = vtx_a_rdata;
      end else if (hit_edge) begin
         wb_dat_r = edge_a_rdata;
      end else begin
         wb_dat_r = reg_rd;
      end
   end

   // start ENQ goes in front of the worker, never while busy
   assign inj_valid = start_pend && !busy;
   assign inj_fire = inj_valid && q_push.ready;
   assign q_push.valid = inj_valid || wk_out.valid;
   assign q_push.t = inj_valid ? '{ttype: ENQ, default: '0} : wk_out.t;
   assign q_push.kind = inj_valid ? JOB_ENQ : wk_out.kind;
   assign wk_out.ready = q_push.ready && !inj_valid;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wb_ack <= 1'b0;
         num_v <= '0;
         enq_limit <= '0;
         start_pend <= 1'b0;
         busy <= 1'b0;
      end else begin
         wb_ack <= wb_cyc && wb_stb && !wb_ack;
         if (wr_cyc && wb_adr == `COLOR_REG_NUM_V) begin
            num_v <= wb_dat_w[15:0];
         end
         if (wr_cyc && wb_adr == `COLOR_REG_ENQ_LIMIT) begin
            enq_limit <= wb_dat_w[15:0];
         end
         if (wr_cyc && wb_adr == `COLOR_REG_START) begin
            start_pend <= 1'b1;
         end else if (inj_fire) begin
            start_pend <= 1'b0;
         end
         busy <= inj_fire || q_pop.valid || !rw_idle || !wk_idle;
      end
   end

   task_queue u_queue (
      .clk(clk),
      .rstn(rstn),
      .push(q_push.snk),
      .pop(q_pop.src)
   );

   graph_mem #(.ENTRY_W(128), .DEPTH(`COLOR_MAX_VERTICES)) u_vtx_mem (
      .clk(clk),
      .a_en(hit_vtx && (rd_req || wr_cyc)),
      .a_we(hit_vtx && wr_cyc),
      .a_addr(wb_adr[VW+3:2]),
      .a_wdata(wb_dat_w),
      .a_rdata(vtx_a_rdata),
      .b_en(vtx_b_en),
      .b_we(vtx_b_we),
      .b_addr(vtx_b_addr),
      .b_wdata(vtx_b_wdata),
      .b_rdata(vtx_b_rdata)
   );

   graph_mem #(.ENTRY_W(32), .DEPTH(`COLOR_MAX_EDGES)) u_edge_mem (
      .clk(clk),
      .a_en(hit_edge && (rd_req || wr_cyc)),
      .a_we(hit_edge && wr_cyc),
      .a_addr(wb_adr[EW+1:2]),
      .a_wdata(wb_dat_w),
      .a_rdata(edge_a_rdata),
      .b_en(edge_b_en),
      .b_we(1'b0),
      .b_addr(edge_b_addr),
      .b_wdata(32'd0),
      .b_rdata(edge_b_rdata)
   );

   color_rw u_rw (
      .clk(clk),
      .rstn(rstn),
      .tin(q_pop.snk),
      .job(job.src),
      .v_en(vtx_b_en),
      .v_we(vtx_b_we),
      .v_addr(vtx_b_addr),
      .v_wdata(vtx_b_wdata),
      .v_rdata(vtx_b_rdata),
      .idle(rw_idle)
   );

   color_worker u_worker (
      .clk(clk),
      .rstn(rstn),
      .job(job.snk),
      .tout(wk_out.src),
      .e_en(edge_b_en),
      .e_addr(edge_b_addr),
      .e_rdata(edge_b_rdata),
      .num_v(num_v),
      .enq_limit(enq_limit),
      .idle(wk_idle)
   );

endmodule

/* rtl/color_worker.sv */
`timescale 1ns/1ns
`include "color_params.svh"

module color_worker import color_pkg::*, tile_pkg::*; (
   input logic clk,
   input logic rstn,
   task_if.snk job,
   task_if.src tout,
   output logic e_en,
   output logic [$clog2(`COLOR_MAX_EDGES)-1:0] e_addr,
   input logic [31:0] e_rdata,
   input logic [15:0] num_v,
   input logic [15:0] enq_limit,
   output logic idle
);

   localparam int EW = $clog2(`COLOR_MAX_EDGES);

   worker_state_e state;
   job_kind_e kind_q;
   logic [15:0] ptr, last, loc_q;
   logic [15:0] s_id, s_deg, s_col;
   logic [16:0] enq_end;
   logic cont;
   logic out_v;
   logic out_enq;
   logic more;
   logic advance;
   logic step;

   assign enq_end = {1'b0, job.t.arg} + {1'b0, enq_limit};

   // ptr walks vertex ids in EXPAND and edge addresses in WALK
   assign more = (ptr != last) || cont;
   // a stalled child freezes ptr and the edge read data
   assign advance = !out_v || tout.ready;
   assign step = (state != WK_IDLE) && more && advance;

   assign e_en = step && (state == WK_WALK);
   assign e_addr = ptr[EW-1:0];
   assign job.ready = (state == WK_IDLE);
   assign idle = (state == WK_IDLE);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= WK_IDLE;
         out_v <= 1'b0;
         cont <= 1'b0;
      end else begin
         if (advance) begin
            out_v <= step;
         end
         if (state == WK_IDLE) begin
            if (job.valid && job.kind == JOB_ENQ) begin
               state <= WK_EXPAND;
               cont <= (enq_end < {1'b0, num_v});
            end else if (job.valid) begin
               state <= WK_WALK;
            end
         end else begin
            // continuation ENQ goes out after the last vertex
            if (step && ptr == last) begin
               cont <= 1'b0;
            end
            if (!more && advance) begin
               state <= WK_IDLE;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state == WK_IDLE && job.valid) begin
         kind_q <= job.kind;
         s_id <= job.t.sender_id;
         s_deg <= job.t.arg;
         s_col <= job.t.sender_color;
         if (job.kind == JOB_ENQ) begin
            ptr <= job.t.arg;
            last <= (enq_end < {1'b0, num_v}) ? enq_end[15:0] : num_v;
         end else begin
            ptr <= job.t.locale;
            last <= job.t.locale + job.t.arg;
         end
      end else if (step) begin
         loc_q <= ptr;
         out_enq <= (ptr == last);
         if (ptr != last) begin
            ptr <= ptr + 1'b1;
         end
      end
   end

   always_comb begin
      tout.t = '0;
      tout.kind = kind_q;
      if (state == WK_WALK) begin
         tout.t.ttype = (kind_q == JOB_DEGREE) ? RECV_DEGREE : RECV_COLOR;
         tout.t.locale = e_rdata[15:0];
         tout.t.arg = s_deg;
         tout.t.sender_id = s_id;
         tout.t.sender_color = s_col;
      end else if (out_enq) begin
         tout.t.ttype = ENQ;
         tout.t.arg = loc_q;
      end else begin
         tout.t.ttype = SEND_DEGREE;
         tout.t.locale = loc_q;
      end
   end

   assign tout.valid = out_v;

endmodule

/* rtl/color_rw.sv */
`timescale 1ns/1ns
`include "color_params.svh"

module color_rw import color_pkg::*, tile_pkg::*; (
   input logic clk,
   input logic rstn,
   task_if.snk tin,
   task_if.src job,
   output logic v_en,
   output logic v_we,
   output logic [$clog2(`COLOR_MAX_VERTICES)-1:0] v_addr,
   output vertex_rec_t v_wdata,
   input vertex_rec_t v_rdata,
   output logic idle
);

   localparam int CW = $clog2(`COLOR_BITMAP_W) + 1;

   rw_state_e state;
   color_task_t cur;
   vertex_rec_t rec;
   color_task_t job_t;
   job_kind_e job_k;
   color_task_t nxt_t;
   job_kind_e nxt_k;
   logic prio;
   logic done;
   logic wr;
   logic pass;

   // full bitmap gives BITMAP_W
   function automatic logic [CW-1:0] lowest_clear(input logic [`COLOR_BITMAP_W-1:0] bm);
      logic [CW-1:0] c;
      c = CW'(`COLOR_BITMAP_W);
      for (int i = `COLOR_BITMAP_W - 1; i >= 0; i--) begin
         if (!bm[i]) begin
            c = CW'(i);
         end
      end
      return c;
   endfunction

   always_comb begin
      rec = v_rdata;
      wr = 1'b0;
      done = 1'b0;
      // higher degree wins, lower id on a tie
      prio = (cur.arg > v_rdata.degree) ||
             ((cur.arg == v_rdata.degree) && (cur.sender_id < cur.locale));
      case (cur.ttype)
         SEND_DEGREE: begin
            if (v_rdata.degree == '0) begin
               rec.color = '0;
               wr = 1'b1;
            end
         end
         RECV_DEGREE: begin
            wr = 1'b1;
            rec.deg_pending = v_rdata.deg_pending - 1'b1;
            if (prio) begin
               rec.col_pending = v_rdata.col_pending + 1'b1;
            end
            done = (rec.deg_pending == '0) && (rec.col_pending == '0);
         end
         RECV_COLOR: begin
            if (prio) begin
               wr = 1'b1;
               rec.scratch[cur.sender_color[CW-2:0]] = 1'b1;
               rec.col_pending = v_rdata.col_pending - 1'b1;
               done = (rec.deg_pending == '0) && (rec.col_pending == '0);
            end
         end
         default: ;
      endcase
      if (done) begin
         rec.color = 16'(lowest_clear(rec.scratch));
      end
   end

   // broadcast jobs reuse locale for eo_begin and arg for the degree
   always_comb begin
      nxt_t = cur;
      nxt_k = JOB_ENQ;
      pass = 1'b0;
      if (cur.ttype == ENQ) begin
         pass = 1'b1;
      end else if ((cur.ttype == SEND_DEGREE && v_rdata.degree != '0) || done) begin
         pass = 1'b1;
         nxt_k = done ? JOB_COLOR : JOB_DEGREE;
         nxt_t.locale = v_rdata.eo_begin[15:0];
         nxt_t.arg = v_rdata.degree;
         nxt_t.sender_id = cur.locale;
         nxt_t.sender_color = rec.color;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= RW_IDLE;
      end else begin
         case (state)
            RW_IDLE: if (tin.valid) state <= RW_READ;
            RW_READ: state <= RW_UPDATE;
            RW_UPDATE: state <= pass ? RW_HANDOFF : RW_IDLE;
            RW_HANDOFF: if (job.ready) state <= RW_IDLE;
            default: state <= RW_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == RW_IDLE && tin.valid) begin
         cur <= tin.t;
      end
      if (state == RW_UPDATE) begin
         job_t <= nxt_t;
         job_k <= nxt_k;
      end
   end

   assign tin.ready = (state == RW_IDLE);
   assign job.valid = (state == RW_HANDOFF);
   assign job.t = job_t;
   assign job.kind = job_k;

   assign v_en = (state == RW_READ) || (state == RW_UPDATE && wr);
   assign v_we = (state == RW_UPDATE) && wr;
   assign v_addr = cur.locale[$clog2(`COLOR_MAX_VERTICES)-1:0];
   assign v_wdata = rec;
   assign idle = (state == RW_IDLE);

endmodule

/* rtl/graph_mem.sv */
`timescale 1ns/1ns

module graph_mem #(
   parameter int ENTRY_W = 128,
   parameter int DEPTH = 256
) (
   input logic clk,
   input logic a_en,
   input logic a_we,
   input logic [$clog2(DEPTH*ENTRY_W/32)-1:0] a_addr,
   input logic [31:0] a_wdata,
   output logic [31:0] a_rdata,
   input logic b_en,
   input logic b_we,
   input logic [$clog2(DEPTH)-1:0] b_addr,
   input logic [ENTRY_W-1:0] b_wdata,
   output logic [ENTRY_W-1:0] b_rdata
);

   localparam int LANES = ENTRY_W / 32;
   localparam int BW = $clog2(DEPTH);

   logic [ENTRY_W-1:0] mem [DEPTH];
   logic [BW-1:0] a_idx;
   int a_sh;

   // lane 0 is the most significant word
   always_comb begin
      a_idx = BW'(a_addr / LANES);
      a_sh = (LANES - 1 - int'(a_addr % LANES)) * 32;
   end

   // read data holds while a port is not enabled
   always_ff @(posedge clk) begin
      if (a_en) begin
         if (a_we) begin
            mem[a_idx][a_sh +: 32] <= a_wdata;
         end
         a_rdata <= mem[a_idx][a_sh +: 32];
      end
      if (b_en) begin
         if (b_we) begin
            mem[b_addr] <= b_wdata;
         end
         b_rdata <= mem[b_addr];
      end
   end

endmodule

/* rtl/task_queue.sv */
`timescale 1ns/1ns
`include "color_params.svh"

module task_queue import color_pkg::*, tile_pkg::*; (
   input logic clk,
   input logic rstn,
   task_if.snk push,
   task_if.src pop
);

   localparam int AW = $clog2(`COLOR_QUEUE_DEPTH);

   color_task_t task_mem [`COLOR_QUEUE_DEPTH];
   job_kind_e kind_mem [`COLOR_QUEUE_DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0] count;
   logic do_push;
   logic do_pop;

   assign push.ready = (count != (AW+1)'(`COLOR_QUEUE_DEPTH));
   assign pop.valid = (count != '0);
   assign pop.t = task_mem[rd_ptr];
   assign pop.kind = kind_mem[rd_ptr];

   assign do_push = push.valid && push.ready;
   assign do_pop = pop.valid && pop.ready;

   always_ff @(posedge clk) begin
      if (do_push) begin
         task_mem[wr_ptr] <= push.t;
         kind_mem[wr_ptr] <= push.kind;
      end
   end

   // pointers wrap naturally, depth is a power of two
   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

/* rtl/task_if.sv */
`timescale 1ns/1ns

interface task_if import color_pkg::*, tile_pkg::*; ();

   logic valid;
   logic ready;
   color_task_t t;
   job_kind_e kind;

   // payload holds from valid until the transfer
   modport src (
      output valid,
      output t,
      output kind,
      input ready
   );

   modport snk (
      input valid,
      input t,
      input kind,
      output ready
   );

endinterface

/* rtl/tile_pkg.sv */
package tile_pkg;

   typedef enum logic [1:0] {
      RW_IDLE,
      RW_READ,
      RW_UPDATE,
      RW_HANDOFF
   } rw_state_e;

   typedef enum logic [1:0] {
      WK_IDLE,
      WK_EXPAND,
      WK_WALK
   } worker_state_e;

   // what the worker does with a job
   typedef enum logic [1:0] {
      JOB_ENQ,
      JOB_DEGREE,
      JOB_COLOR
   } job_kind_e;

endpackage

/* rtl/color_pkg.sv */
package color_pkg;

   typedef enum logic [1:0] {
      ENQ = 2'd0,
      SEND_DEGREE = 2'd1,
      RECV_DEGREE = 2'd2,
      RECV_COLOR = 2'd3
   } task_type_e;

   // host word 0 is eo_begin, word 3 holds degree and color
   typedef struct packed {
      logic [31:0] eo_begin;
      logic [15:0] deg_pending;
      logic [15:0] col_pending;
      logic [31:0] scratch;
      logic [15:0] degree;
      logic [15:0] color;
   } vertex_rec_t;

   // arg is the enq start or the sender degree
   typedef struct packed {
      task_type_e ttype;
      logic [15:0] locale;
      logic [15:0] arg;
      logic [15:0] sender_id;
      logic [15:0] sender_color;
   } color_task_t;

endpackage

/* include/color_params.svh */
`ifndef COLOR_PARAMS_SVH
`define COLOR_PARAMS_SVH

// task queue entries
`define COLOR_QUEUE_DEPTH 64

// memory sizes in entries
`define COLOR_MAX_VERTICES 256
`define COLOR_MAX_EDGES 1024

// used-color bitmap, one bit per color
`define COLOR_BITMAP_W 32

// wishbone byte offsets
`define COLOR_REG_NUM_V 16'h0004
`define COLOR_REG_ENQ_LIMIT 16'h0024
`define COLOR_REG_START 16'h0028
`define COLOR_REG_STATUS 16'h002C
// four words per vertex record
`define COLOR_VTX_BASE 16'h1000
`define COLOR_EDGE_BASE 16'h2000

`endif
